// File: filelist.f
oq_pkg.sv
output_queues_regs.sv
oq_hash_splitter.sv
oq_queue_bank.sv
oq_output_arbiter.sv
output_queues_top.sv
tb_output_queues.sv

// File: oq_hash_splitter.sv
`timescale 1ns/1ps

module oq_hash_splitter (
   input  logic                  ACLK,
   input  logic                  ARESETN,
   input  logic                  pkt_valid,
   input  oq_pkg::pkt_t          pkt_in,
   input  oq_pkg::split_ratios_t split_ratios,
   output logic                  tag_valid,
   output oq_pkg::tagged_pkt_t   tag_pkt
);

   oq_pkg::qidx_t queue_idx;

   // index is the number of ratios at or below the hash.
   always_comb begin
      queue_idx = '0;
      if (split_ratios.ratio_0 <= pkt_in.hash) queue_idx = queue_idx + 3'd1;
      if (split_ratios.ratio_1 <= pkt_in.hash) queue_idx = queue_idx + 3'd1;
      if (split_ratios.ratio_2 <= pkt_in.hash) queue_idx = queue_idx + 3'd1;
      if (split_ratios.ratio_3 <= pkt_in.hash) queue_idx = queue_idx + 3'd1;
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         tag_valid <= 1'b0;
      end else begin
         tag_valid <= pkt_valid;
      end
   end

   always_ff @(posedge ACLK) begin
      if (pkt_valid) begin
         tag_pkt.pkt   <= pkt_in;
         tag_pkt.queue <= queue_idx;
      end
   end

endmodule

// File: oq_output_arbiter.sv
`timescale 1ns/1ps

module oq_output_arbiter (
   input  logic                          ACLK,
   input  logic                          ARESETN,
   input  logic [oq_pkg::num_queues-1:0] q_not_empty,
   input  logic                          out_pop,
   output oq_pkg::qidx_t                 sel_queue,
   output logic                          sel_valid
);

   oq_pkg::qidx_t rr_ptr;

   // first non-empty queue at or after the pointer.
   always_comb begin
      int cand;
      sel_valid = 1'b0;
      sel_queue = '0;
      cand      = 0;
      // walk backwards so the nearest candidate wins.
      for (int i = oq_pkg::num_queues - 1; i >= 0; i--) begin
         cand = int'(rr_ptr) + i;
         if (cand >= oq_pkg::num_queues) cand = cand - oq_pkg::num_queues;
         if (q_not_empty[cand]) begin
            sel_valid = 1'b1;
            sel_queue = oq_pkg::qidx_t'(cand);
         end
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rr_ptr <= '0;
      end else if (out_pop && sel_valid) begin
         if (sel_queue == oq_pkg::qidx_t'(oq_pkg::num_queues - 1)) begin
            rr_ptr <= '0;
         end else begin
            rr_ptr <= sel_queue + 3'd1; // one past the popped queue.
         end
      end
   end

endmodule

// File: oq_pkg.sv
package oq_pkg;

   // fixed by the register map, which has five drop counts.
   localparam int num_queues = 5;

   typedef logic [31:0] word_t;
   typedef logic [31:0] hash_t;
   typedef logic [2:0]  qidx_t;
   typedef logic [1:0]  resp_t;

   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_slverr = 2'b10;

   // offsets on address bits [7:0].
   localparam logic [7:0] reg_reset_drop_counts = 8'h01;
   localparam logic [7:0] reg_drop_count_base   = 8'h10; // 0x10 to 0x14.
   localparam logic [7:0] reg_split_ratio_base  = 8'h20; // 0x20 to 0x23.

   // about 1/5, 2/5, 3/5 and 4/5 of the hash range.
   localparam word_t split_ratio_0 = 32'd858993460;
   localparam word_t split_ratio_1 = 32'd1717986919;
   localparam word_t split_ratio_2 = 32'd2576980378;
   localparam word_t split_ratio_3 = 32'd3435973837;

   typedef struct packed {
      hash_t hash;
      word_t data;
   } pkt_t;

   typedef struct packed {
      pkt_t  pkt;
      qidx_t queue;
   } tagged_pkt_t;

   typedef struct packed {
      word_t ratio_0;
      word_t ratio_1;
      word_t ratio_2;
      word_t ratio_3;
   } split_ratios_t;

   typedef struct packed {
      word_t count_0;
      word_t count_1;
      word_t count_2;
      word_t count_3;
      word_t count_4;
   } drop_counts_t;

   typedef enum logic [1:0] {
      wr_idle,
      wr_data,
      wr_resp
   } wr_state_t;

   typedef enum logic {
      rd_idle,
      rd_resp
   } rd_state_t;

endpackage

// File: oq_queue_bank.sv
`timescale 1ns/1ps

module oq_queue_bank #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                          ACLK,
   input  logic                          ARESETN,
   input  logic                          tag_valid,
   input  oq_pkg::tagged_pkt_t           tag_pkt,
   input  logic                          pop,
   input  oq_pkg::qidx_t                 pop_queue,
   input  logic                          reset_drop_counts,
   output logic [oq_pkg::num_queues-1:0] q_not_empty,
   output oq_pkg::pkt_t                  head_pkt,
   output oq_pkg::drop_counts_t          drop_counts
);

   // depth is a power of two, so the pointers wrap on their own.
   localparam int ptr_w = $clog2(QUEUE_DEPTH);
   localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

   oq_pkg::pkt_t  mem      [oq_pkg::num_queues][QUEUE_DEPTH];
   logic [ptr_w-1:0] wr_ptr [oq_pkg::num_queues];
   logic [ptr_w-1:0] rd_ptr [oq_pkg::num_queues];
   logic [cnt_w-1:0] count  [oq_pkg::num_queues];
   oq_pkg::word_t drop_cnt [oq_pkg::num_queues];

   logic [oq_pkg::num_queues-1:0] push, pop_q, full, accept, drop;

   always_comb begin
      for (int q = 0; q < oq_pkg::num_queues; q++) begin
         push[q]        = tag_valid && (tag_pkt.queue == oq_pkg::qidx_t'(q));
         pop_q[q]       = pop && (pop_queue == oq_pkg::qidx_t'(q)) && (count[q] != '0);
         full[q]        = (count[q] == cnt_w'(QUEUE_DEPTH));
         // a pop in the same cycle frees the slot.
         accept[q]      = push[q] && (!full[q] || pop_q[q]);
         drop[q]        = push[q] && full[q] && !pop_q[q];
         q_not_empty[q] = (count[q] != '0);
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         for (int q = 0; q < oq_pkg::num_queues; q++) begin
            wr_ptr[q]   <= '0;
            rd_ptr[q]   <= '0;
            count[q]    <= '0;
            drop_cnt[q] <= '0;
         end
      end else begin
         for (int q = 0; q < oq_pkg::num_queues; q++) begin
            if (accept[q]) wr_ptr[q] <= wr_ptr[q] + 1'b1;
            if (pop_q[q]) rd_ptr[q] <= rd_ptr[q] + 1'b1;
            case ({accept[q], pop_q[q]})
               2'b10:   count[q] <= count[q] + 1'b1;
               2'b01:   count[q] <= count[q] - 1'b1;
               default: count[q] <= count[q];
            endcase
            if (reset_drop_counts) begin
               drop_cnt[q] <= '0; // held clear while the control is set.
            end else if (drop[q]) begin
               drop_cnt[q] <= drop_cnt[q] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge ACLK) begin
      for (int q = 0; q < oq_pkg::num_queues; q++) begin
         if (accept[q]) mem[q][wr_ptr[q]] <= tag_pkt.pkt;
      end
   end

   always_comb begin
      head_pkt = '0;
      if (pop_queue < oq_pkg::qidx_t'(oq_pkg::num_queues)) begin
         head_pkt = mem[pop_queue][rd_ptr[pop_queue]];
      end
   end

   assign drop_counts.count_0 = drop_cnt[0];
   assign drop_counts.count_1 = drop_cnt[1];
   assign drop_counts.count_2 = drop_cnt[2];
   assign drop_counts.count_3 = drop_cnt[3];
   assign drop_counts.count_4 = drop_cnt[4];

endmodule

// File: output_queues_regs.sv
`timescale 1ns/1ps

module output_queues_regs #(
   parameter int ADDR_WIDTH = 32,
   parameter int DATA_WIDTH = 32
) (
   input  logic                    ACLK,
   input  logic                    ARESETN,

   input  logic [ADDR_WIDTH-1:0]   AWADDR,
   input  logic                    AWVALID,
   output logic                    AWREADY,

   input  logic [DATA_WIDTH-1:0]   WDATA,
   input  logic [DATA_WIDTH/8-1:0] WSTRB,
   input  logic                    WVALID,
   output logic                    WREADY,

   output oq_pkg::resp_t           BRESP,
   output logic                    BVALID,
   input  logic                    BREADY,

   input  logic [ADDR_WIDTH-1:0]   ARADDR,
   input  logic                    ARVALID,
   output logic                    ARREADY,

   output logic [DATA_WIDTH-1:0]   RDATA,
   output oq_pkg::resp_t           RRESP,
   output logic                    RVALID,
   input  logic                    RREADY,

   input  oq_pkg::drop_counts_t    drop_counts,
   output oq_pkg::split_ratios_t   split_ratios,
   output logic                    reset_drop_counts
);

   oq_pkg::wr_state_t     wr_state, wr_state_next;
   oq_pkg::rd_state_t     rd_state, rd_state_next;
   logic [7:0]            wr_offset, wr_offset_next;
   logic [7:0]            rd_offset, rd_offset_next;
   oq_pkg::resp_t         bresp_next;
   oq_pkg::split_ratios_t ratios_next;
   logic                  reset_drop_counts_next;
   oq_pkg::word_t         wdata_word;
   oq_pkg::word_t         rd_word;
   oq_pkg::resp_t         rd_resp;

   assign wdata_word = oq_pkg::word_t'(WDATA); // byte strobes are not used.

   assign AWREADY = (wr_state == oq_pkg::wr_idle);
   assign WREADY  = (wr_state == oq_pkg::wr_data);
   assign BVALID  = (wr_state == oq_pkg::wr_resp);
   assign ARREADY = (rd_state == oq_pkg::rd_idle);
   assign RVALID  = (rd_state == oq_pkg::rd_resp);

   // write side.
   always_comb begin
      wr_state_next          = wr_state;
      wr_offset_next         = wr_offset;
      bresp_next             = BRESP;
      ratios_next            = split_ratios;
      reset_drop_counts_next = reset_drop_counts;
      case (wr_state)
         oq_pkg::wr_idle: begin
            if (AWVALID) begin
               wr_offset_next = AWADDR[7:0];
               wr_state_next  = oq_pkg::wr_data;
            end
         end
         oq_pkg::wr_data: begin
            if (WVALID) begin
               bresp_next = oq_pkg::resp_okay;
               case (wr_offset)
                  oq_pkg::reg_reset_drop_counts:       reset_drop_counts_next = wdata_word[0];
                  oq_pkg::reg_split_ratio_base:        ratios_next.ratio_0 = wdata_word;
                  oq_pkg::reg_split_ratio_base + 8'd1: ratios_next.ratio_1 = wdata_word;
                  oq_pkg::reg_split_ratio_base + 8'd2: ratios_next.ratio_2 = wdata_word;
                  oq_pkg::reg_split_ratio_base + 8'd3: ratios_next.ratio_3 = wdata_word;
                  // drop counts are read only and land here too.
                  default: bresp_next = oq_pkg::resp_slverr;
               endcase
               wr_state_next = oq_pkg::wr_resp;
            end
         end
         oq_pkg::wr_resp: begin
            if (BREADY) begin
               wr_state_next = oq_pkg::wr_idle;
            end
         end
         default: wr_state_next = oq_pkg::wr_idle;
      endcase
   end

   // read side.
   always_comb begin
      rd_state_next  = rd_state;
      rd_offset_next = rd_offset;
      case (rd_state)
         oq_pkg::rd_idle: begin
            if (ARVALID) begin
               rd_offset_next = ARADDR[7:0];
               rd_state_next  = oq_pkg::rd_resp;
            end
         end
         oq_pkg::rd_resp: begin
            if (RREADY) begin
               rd_state_next = oq_pkg::rd_idle;
            end
         end
         default: rd_state_next = oq_pkg::rd_idle;
      endcase
   end

   always_comb begin
      rd_word = '0;
      rd_resp = oq_pkg::resp_okay;
      case (rd_offset)
         oq_pkg::reg_reset_drop_counts:       rd_word = {31'b0, reset_drop_counts};
         oq_pkg::reg_drop_count_base:         rd_word = drop_counts.count_0;
         oq_pkg::reg_drop_count_base + 8'd1:  rd_word = drop_counts.count_1;
         oq_pkg::reg_drop_count_base + 8'd2:  rd_word = drop_counts.count_2;
         oq_pkg::reg_drop_count_base + 8'd3:  rd_word = drop_counts.count_3;
         oq_pkg::reg_drop_count_base + 8'd4:  rd_word = drop_counts.count_4;
         oq_pkg::reg_split_ratio_base:        rd_word = split_ratios.ratio_0;
         oq_pkg::reg_split_ratio_base + 8'd1: rd_word = split_ratios.ratio_1;
         oq_pkg::reg_split_ratio_base + 8'd2: rd_word = split_ratios.ratio_2;
         oq_pkg::reg_split_ratio_base + 8'd3: rd_word = split_ratios.ratio_3;
         default: rd_resp = oq_pkg::resp_slverr;
      endcase
   end

   assign RDATA = RVALID ? DATA_WIDTH'(rd_word) : '0;
   assign RRESP = RVALID ? rd_resp : oq_pkg::resp_okay;

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state             <= oq_pkg::wr_idle;
         rd_state             <= oq_pkg::rd_idle;
         BRESP                <= oq_pkg::resp_okay;
         reset_drop_counts    <= 1'b0;
         split_ratios.ratio_0 <= oq_pkg::split_ratio_0;
         split_ratios.ratio_1 <= oq_pkg::split_ratio_1;
         split_ratios.ratio_2 <= oq_pkg::split_ratio_2;
         split_ratios.ratio_3 <= oq_pkg::split_ratio_3;
      end else begin
         wr_state          <= wr_state_next;
         rd_state          <= rd_state_next;
         BRESP             <= bresp_next;
         reset_drop_counts <= reset_drop_counts_next;
         split_ratios      <= ratios_next;
      end
   end

   always_ff @(posedge ACLK) begin
      wr_offset <= wr_offset_next;
      rd_offset <= rd_offset_next;
   end

endmodule

// File: output_queues_top.sv
`timescale 1ns/1ps

module output_queues_top #(
   parameter int ADDR_WIDTH  = 32,
   parameter int DATA_WIDTH  = 32,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                    ACLK,
   input  logic                    ARESETN,

   input  logic [ADDR_WIDTH-1:0]   AWADDR,
   input  logic                    AWVALID,
   output logic                    AWREADY,
   input  logic [DATA_WIDTH-1:0]   WDATA,
   input  logic [DATA_WIDTH/8-1:0] WSTRB,
   input  logic                    WVALID,
   output logic                    WREADY,
   output oq_pkg::resp_t           BRESP,
   output logic                    BVALID,
   input  logic                    BREADY,
   input  logic [ADDR_WIDTH-1:0]   ARADDR,
   input  logic                    ARVALID,
   output logic                    ARREADY,
   output logic [DATA_WIDTH-1:0]   RDATA,
   output oq_pkg::resp_t           RRESP,
   output logic                    RVALID,
   input  logic                    RREADY,

   input  logic                    pkt_valid,
   input  oq_pkg::pkt_t            pkt_in,
   input  logic                    out_pop,
   output logic                    out_valid,
   output oq_pkg::pkt_t            out_pkt,
   output oq_pkg::qidx_t           out_queue
);

   oq_pkg::split_ratios_t         split_ratios;
   oq_pkg::drop_counts_t          drop_counts;
   logic                          reset_drop_counts;
   logic                          tag_valid;
   oq_pkg::tagged_pkt_t           tag_pkt;
   logic [oq_pkg::num_queues-1:0] q_not_empty;
   oq_pkg::qidx_t                 sel_queue;
   logic                          sel_valid;
   logic                          pop;

   assign pop       = out_pop && sel_valid; // pops only count with a packet shown.
   assign out_valid = sel_valid;
   assign out_queue = sel_queue;

   output_queues_regs #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH)
   ) output_queues_regs_i (
      .ACLK, .ARESETN,
      .AWADDR, .AWVALID, .AWREADY,
      .WDATA, .WSTRB, .WVALID, .WREADY,
      .BRESP, .BVALID, .BREADY,
      .ARADDR, .ARVALID, .ARREADY,
      .RDATA, .RRESP, .RVALID, .RREADY,
      .drop_counts, .split_ratios, .reset_drop_counts
   );

   oq_hash_splitter oq_hash_splitter_i (
      .ACLK, .ARESETN,
      .pkt_valid, .pkt_in, .split_ratios,
      .tag_valid, .tag_pkt
   );

   oq_queue_bank #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) oq_queue_bank_i (
      .ACLK, .ARESETN,
      .tag_valid, .tag_pkt,
      .pop, .pop_queue (sel_queue),
      .reset_drop_counts,
      .q_not_empty, .head_pkt (out_pkt), .drop_counts
   );

   oq_output_arbiter oq_output_arbiter_i (
      .ACLK, .ARESETN,
      .q_not_empty, .out_pop,
      .sel_queue, .sel_valid
   );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_output_queues -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation passed"

// File: tb_output_queues.sv
`timescale 1ns/1ps

module tb_output_queues;

   localparam int ADDR_WIDTH  = 32;
   localparam int DATA_WIDTH  = 32;
   localparam int QUEUE_DEPTH = 4;
   localparam int watchdog_cycles = 20000; // tests need under 500 cycles.

   logic                    ACLK;
   logic                    ARESETN;
   logic [ADDR_WIDTH-1:0]   AWADDR, ARADDR;
   logic                    AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
   logic                    ARVALID, ARREADY, RVALID, RREADY;
   logic [DATA_WIDTH-1:0]   WDATA, RDATA;
   logic [DATA_WIDTH/8-1:0] WSTRB;
   oq_pkg::resp_t           BRESP, RRESP;
   logic                    pkt_valid, out_pop, out_valid;
   oq_pkg::pkt_t            pkt_in, out_pkt;
   oq_pkg::qidx_t           out_queue;

   // reference model of the queues.
   oq_pkg::pkt_t  model_q     [oq_pkg::num_queues][$];
   oq_pkg::word_t model_drops [oq_pkg::num_queues];
   oq_pkg::word_t ratio       [4];
   int            rr_ptr;
   int            seed = 91;

   output_queues_top #(
      .ADDR_WIDTH  (ADDR_WIDTH),
      .DATA_WIDTH  (DATA_WIDTH),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) output_queues_top_i (.*);

   always #50 ACLK = ~ACLK;

   task automatic stop_on_failure();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
      assert (got == exp) else begin
         $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic axi_write(input logic [7:0] offset, input oq_pkg::word_t data,
                            input oq_pkg::resp_t exp_resp);
      @(posedge ACLK);
      AWADDR  <= ADDR_WIDTH'(offset);
      AWVALID <= 1'b1;
      @(negedge ACLK);
      while (!AWREADY) @(negedge ACLK);
      @(posedge ACLK);
      AWVALID <= 1'b0;
      WDATA   <= DATA_WIDTH'(data);
      WVALID  <= 1'b1;
      @(negedge ACLK);
      while (!WREADY) @(negedge ACLK);
      @(posedge ACLK);
      WVALID <= 1'b0;
      BREADY <= 1'b1;
      @(negedge ACLK);
      while (!BVALID) @(negedge ACLK);
      check_value(BRESP, exp_resp, "BRESP");
      @(posedge ACLK);
      BREADY <= 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] offset, output oq_pkg::word_t data,
                           output oq_pkg::resp_t resp);
      @(posedge ACLK);
      ARADDR  <= ADDR_WIDTH'(offset);
      ARVALID <= 1'b1;
      @(negedge ACLK);
      while (!ARREADY) @(negedge ACLK);
      @(posedge ACLK);
      ARVALID <= 1'b0;
      RREADY  <= 1'b1;
      @(negedge ACLK);
      while (!RVALID) @(negedge ACLK);
      data = RDATA;
      resp = RRESP;
      @(posedge ACLK);
      RREADY <= 1'b0;
   endtask

   task automatic check_read(input logic [7:0] offset, input oq_pkg::word_t exp_data,
                             input oq_pkg::resp_t exp_resp);
      oq_pkg::word_t data;
      oq_pkg::resp_t resp;
      axi_read(offset, data, resp);
      check_value(data, exp_data, $sformatf("RDATA at 0x%02h", offset));
      check_value(resp, exp_resp, $sformatf("RRESP at 0x%02h", offset));
   endtask

   // queue index is the count of ratios at or below the hash.
   function automatic int route(input oq_pkg::hash_t hash);
      int n;
      n = 0;
      for (int i = 0; i < 4; i++) begin
         if (ratio[i] <= hash) n++;
      end
      return n;
   endfunction

   function automatic int expected_queue();
      int q;
      for (int i = 0; i < oq_pkg::num_queues; i++) begin
         q = (rr_ptr + i) % oq_pkg::num_queues;
         if (model_q[q].size() > 0) return q;
      end
      return -1;
   endfunction

   task automatic send_pkt(input oq_pkg::hash_t hash, input oq_pkg::word_t data);
      oq_pkg::pkt_t p;
      int q;
      p.hash = hash;
      p.data = data;
      q = route(hash);
      @(posedge ACLK);
      pkt_valid <= 1'b1;
      pkt_in    <= p;
      @(posedge ACLK);
      pkt_valid <= 1'b0;
      if (model_q[q].size() == QUEUE_DEPTH) model_drops[q]++; // full queue drops.
      else model_q[q].push_back(p);
   endtask

   task automatic pop_pkt();
      int q;
      oq_pkg::pkt_t exp;
      q = expected_queue();
      if (q < 0) begin
         $display("A pop was requested while every model queue is empty");
         stop_on_failure();
      end
      @(negedge ACLK);
      while (!out_valid) @(negedge ACLK);
      check_value(out_queue, q, "out_queue");
      exp = model_q[q].pop_front();
      check_value(out_pkt, exp, "out_pkt");
      @(posedge ACLK);
      out_pop <= 1'b1;
      @(posedge ACLK);
      out_pop <= 1'b0;
      rr_ptr = (q + 1) % oq_pkg::num_queues;
   endtask

   task automatic test_reset_values();
      @(negedge ACLK);
      check_value(AWREADY, 1'b1, "AWREADY after reset");
      check_value(ARREADY, 1'b1, "ARREADY after reset");
      check_value(WREADY, 1'b0, "WREADY after reset");
      check_value(BVALID, 1'b0, "BVALID after reset");
      check_value(RVALID, 1'b0, "RVALID after reset");
      check_value(out_valid, 1'b0, "out_valid after reset");
      for (int i = 0; i < 4; i++) check_read(8'h20 + 8'(i), ratio[i], oq_pkg::resp_okay);
      for (int i = 0; i < 5; i++) check_read(8'h10 + 8'(i), '0, oq_pkg::resp_okay);
      check_read(8'h01, '0, oq_pkg::resp_okay);
   endtask

   task automatic test_register_access();
      ratio[0] = 32'h2000_0000;
      ratio[1] = 32'h6000_0000;
      ratio[2] = 32'hA000_0000;
      ratio[3] = 32'hE000_0000;
      for (int i = 0; i < 4; i++) axi_write(8'h20 + 8'(i), ratio[i], oq_pkg::resp_okay);
      for (int i = 0; i < 4; i++) check_read(8'h20 + 8'(i), ratio[i], oq_pkg::resp_okay);
      axi_write(8'h10, 32'h1234, oq_pkg::resp_slverr); // drop counts are read only.
      axi_write(8'h7F, 32'h1234, oq_pkg::resp_slverr);
      check_read(8'h7F, '0, oq_pkg::resp_slverr);
   endtask

   task automatic test_steering();
      oq_pkg::hash_t h;
      for (int i = 0; i < 44; i++) begin
         if (i < 4) h = ratio[i]; // edge hashes first.
         else h = oq_pkg::hash_t'($random(seed));
         send_pkt(h, oq_pkg::word_t'(i));
         pop_pkt();
      end
   endtask

   task automatic test_drops();
      for (int i = 0; i < QUEUE_DEPTH + 3; i++) send_pkt(ratio[1] + i, 32'h100 + i);
      repeat (3) @(posedge ACLK); // last packet lands.
      for (int q = 0; q < 5; q++) check_read(8'h10 + 8'(q), model_drops[q], oq_pkg::resp_okay);
      axi_write(8'h01, 32'd1, oq_pkg::resp_okay);
      for (int q = 0; q < 5; q++) model_drops[q] = '0;
      axi_write(8'h01, 32'd0, oq_pkg::resp_okay);
      check_read(8'h12, '0, oq_pkg::resp_okay);
      repeat (QUEUE_DEPTH) pop_pkt();
   endtask

   task automatic test_round_robin();
      for (int rep = 0; rep < 2; rep++) begin
         send_pkt(32'h10 + rep, 32'h200 + rep);
         send_pkt(ratio[0] + rep, 32'h210 + rep);
         send_pkt(ratio[2] + rep, 32'h230 + rep);
      end
      repeat (3) @(posedge ACLK);
      repeat (6) pop_pkt();
      @(negedge ACLK);
      check_value(out_valid, 1'b0, "out_valid after draining");
   endtask

   initial begin
      ACLK      = 1'b0;
      ARESETN   <= 1'b0;
      AWADDR    <= '0;
      AWVALID   <= 1'b0;
      WDATA     <= '0;
      WSTRB     <= '1;
      WVALID    <= 1'b0;
      BREADY    <= 1'b0;
      ARADDR    <= '0;
      ARVALID   <= 1'b0;
      RREADY    <= 1'b0;
      pkt_valid <= 1'b0;
      pkt_in    <= '0;
      out_pop   <= 1'b0;
      for (int q = 0; q < oq_pkg::num_queues; q++) model_drops[q] = '0;
      ratio[0] = 32'd858993460;
      ratio[1] = 32'd1717986919;
      ratio[2] = 32'd2576980378;
      ratio[3] = 32'd3435973837;
      rr_ptr   = 0;
      repeat (16) @(posedge ACLK);
      ARESETN <= 1'b1;
      test_reset_values();
      test_register_access();
      test_steering();
      test_drops();
      test_round_robin();
      $display("Test completed successfully");
      $finish;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge ACLK);
      $display("Watchdog expired before the tests finished");
      stop_on_failure();
   end

endmodule
